// File: project.f
rtl/arm_pkg.sv
rtl/fetch_stage.sv
rtl/decode_unit.sv
rtl/register_file.sv
rtl/forwarding_unit.sv
rtl/shifter.sv
rtl/alu.sv
rtl/arm_core.sv
testbench/arm_core_tb.sv

// File: rtl/alu.sv
// Arithmetic and logic unit
`timescale 1ns/1ps
`default_nettype none

module alu import arm_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  logic    carry_in,
  input  alu_op_t op,
  output word_t   result,
  output flags_t  flags
);

  logic [32:0] wide;   // Sum, or subtrahend with borrow
  logic        c;
  logic        v;

  always_comb begin
    wide   = '0;
    result = '0;
    c      = carry_in;  // Logic ops pass C through
    v      = 1'b0;      // V held by the status register for logic ops
    case (op)
      ALU_ADD, ALU_ADC: begin
        wide   = {1'b0, a} + {1'b0, b} + 33'(op == ALU_ADC && carry_in);
        result = wide[31:0];
        c      = wide[32];
        v      = ~(a[31] ^ b[31]) & (a[31] ^ result[31]);
      end
      ALU_SUB, ALU_SBC: begin
        wide   = {1'b0, b} + 33'(op == ALU_SBC && carry_in);
        result = a - wide[31:0];
        c      = {1'b0, a} < wide;  // Set on borrow
        v      = (a[31] ^ b[31]) & (a[31] ^ result[31]);
      end
      ALU_RSB, ALU_RSC: begin
        wide   = {1'b0, a} + 33'(op == ALU_RSC && carry_in);
        result = b - wide[31:0];
        c      = {1'b0, b} < wide;
        v      = (b[31] ^ a[31]) & (b[31] ^ result[31]);
      end
      ALU_AND:  result = a & b;
      ALU_ORR:  result = a | b;
      ALU_EOR:  result = a ^ b;
      ALU_MOVA: result = a;
      ALU_MOVB: result = b;
      ALU_MVN:  result = ~b;
      ALU_BIC:  result = a & ~b;
      default:  result = '0;
    endcase
  end

  assign flags = {result[31], result == '0, c, v};

endmodule

`default_nettype wire

// File: rtl/arm_core.sv
// Five-stage ARM pipeline core
`timescale 1ns/1ps
`default_nettype none

module arm_core import arm_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  output logic      wb_en,
  output reg_addr_t wb_rd,
  output word_t     wb_data,
  output flags_t    psr_flags
);

  word_t       id_instr, id_next_pc;
  logic        branch_taken;
  word_t       branch_target;
  reg_addr_t   id_rn, id_rm, id_rd;
  alu_op_t     id_alu_op;
  shift_am_t   id_shift_am;
  logic [11:0] id_shift_field;
  logic        id_set_flags, id_rf_write, id_uses_rm;
  word_t       rf_pa, rf_pb;
  fwd_sel_t    fwd_a, fwd_b;
  word_t       id_op_a, id_op_b;
  flags_t      cond_flags;

  word_t       ex_op_a, ex_op_b;
  alu_op_t     ex_alu_op;
  shift_am_t   ex_shift_am;
  logic [11:0] ex_shift_field;
  reg_addr_t   ex_rd;
  logic        ex_we, ex_set_flags;
  word_t       ex_operand2, ex_result;
  flags_t      alu_flags, ex_flags;

  word_t       mem_result;
  reg_addr_t   mem_rd;
  logic        mem_we;

  fetch_stage fetch_i (
    .clk, .reset, .branch_taken, .branch_target, .id_instr, .id_next_pc
  );

  decode_unit decode_i (
    .instr(id_instr), .next_pc(id_next_pc), .cond_flags,
    .rn(id_rn), .rm(id_rm), .rd(id_rd), .alu_op(id_alu_op), .shift_am(id_shift_am),
    .shift_field(id_shift_field), .set_flags(id_set_flags), .rf_write(id_rf_write),
    .uses_rm(id_uses_rm), .branch_taken, .branch_target
  );

  register_file regs_i (
    .clk, .reset, .ra(id_rn), .rb(id_rm), .pa(rf_pa), .pb(rf_pb),
    .we(wb_en), .wa(wb_rd), .wd(wb_data)
  );

  forwarding_unit fwd_i (
    .id_rn, .id_rm, .uses_rm(id_uses_rm), .ex_rd, .mem_rd, .wb_rd,
    .ex_we, .mem_we, .wb_we(wb_en), .fwd_a, .fwd_b
  );

  function automatic word_t fwd_mux(fwd_sel_t sel, word_t rf_val, word_t ex_val,
                                    word_t mem_val, word_t wb_val);
    case (sel)
      FWD_EX:  return ex_val;
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return rf_val;
    endcase
  endfunction

  always_comb begin
    id_op_a = fwd_mux(fwd_a, rf_pa, ex_result, mem_result, wb_data);
    id_op_b = fwd_mux(fwd_b, rf_pb, ex_result, mem_result, wb_data);
  end

  shifter shift_i (
    .rm_val(ex_op_b), .shift_field(ex_shift_field), .shift_am(ex_shift_am),
    .operand2(ex_operand2)
  );

  alu alu_i (
    .a(ex_op_a), .b(ex_operand2), .carry_in(psr_flags[1]), .op(ex_alu_op),
    .result(ex_result), .flags(alu_flags)
  );

  // Logic ops leave V as it was
  assign ex_flags   = {alu_flags[3:1], (ex_alu_op >= ALU_AND) ? psr_flags[0] : alu_flags[0]};
  assign cond_flags = ex_set_flags ? ex_flags : psr_flags;  // Branch sees EX result first

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_we        <= 1'b0;
      ex_set_flags <= 1'b0;
      mem_we       <= 1'b0;
      wb_en        <= 1'b0;
      psr_flags    <= '0;
    end else begin
      ex_we        <= id_rf_write;
      ex_set_flags <= id_set_flags;
      mem_we       <= ex_we;
      wb_en        <= mem_we;
      if (ex_set_flags) psr_flags <= ex_flags;
    end
  end

  always_ff @(posedge clk) begin
    ex_op_a        <= id_op_a;
    ex_op_b        <= id_op_b;
    ex_alu_op      <= id_alu_op;
    ex_shift_am    <= id_shift_am;
    ex_shift_field <= id_shift_field;
    ex_rd          <= id_rd;
    mem_result     <= ex_result;
    mem_rd         <= ex_rd;
    wb_data        <= mem_result;
    wb_rd          <= mem_rd;
  end

  assert property (@(posedge clk) reset |-> !wb_en)
    else $error("write-back active during reset");

endmodule

`default_nettype wire

// File: rtl/arm_pkg.sv
// ARM pipeline shared definitions
`default_nettype none

package arm_pkg;

  typedef logic [31:0] word_t;      // Data and address word
  typedef logic [3:0]  reg_addr_t;  // Register number
  typedef logic [3:0]  alu_op_t;
  typedef logic [3:0]  cond_t;
  typedef logic [3:0]  flags_t;     // N Z C V, N on top
  typedef logic [1:0]  shift_am_t;  // Operand-2 mode
  typedef logic [1:0]  fwd_sel_t;

  // ALU operation codes
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_ADC  = 4'd1;
  localparam alu_op_t ALU_SUB  = 4'd2;
  localparam alu_op_t ALU_SBC  = 4'd3;
  localparam alu_op_t ALU_RSB  = 4'd4;
  localparam alu_op_t ALU_RSC  = 4'd5;
  localparam alu_op_t ALU_AND  = 4'd6;
  localparam alu_op_t ALU_ORR  = 4'd7;
  localparam alu_op_t ALU_EOR  = 4'd8;
  localparam alu_op_t ALU_MOVA = 4'd9;
  localparam alu_op_t ALU_MOVB = 4'd10;
  localparam alu_op_t ALU_MVN  = 4'd11;
  localparam alu_op_t ALU_BIC  = 4'd12;

  localparam shift_am_t AM_ROT_IMM   = 2'b00;
  localparam shift_am_t AM_SHIFT_REG = 2'b11;

  localparam fwd_sel_t FWD_NONE = 2'd0;
  localparam fwd_sel_t FWD_EX   = 2'd1;
  localparam fwd_sel_t FWD_MEM  = 2'd2;
  localparam fwd_sel_t FWD_WB   = 2'd3;

  localparam cond_t COND_EQ = 4'h0;
  localparam cond_t COND_NE = 4'h1;
  localparam cond_t COND_CS = 4'h2;
  localparam cond_t COND_CC = 4'h3;
  localparam cond_t COND_MI = 4'h4;
  localparam cond_t COND_PL = 4'h5;
  localparam cond_t COND_VS = 4'h6;
  localparam cond_t COND_VC = 4'h7;
  localparam cond_t COND_HI = 4'h8;
  localparam cond_t COND_LS = 4'h9;
  localparam cond_t COND_GE = 4'ha;
  localparam cond_t COND_LT = 4'hb;
  localparam cond_t COND_GT = 4'hc;
  localparam cond_t COND_LE = 4'hd;
  localparam cond_t COND_AL = 4'he;

  localparam int    ROM_BYTES = 256;
  localparam string ROM_FILE  = "testbench/program.hex";
  localparam word_t PC_STEP   = 32'd4;

endpackage

`default_nettype wire

// File: rtl/decode_unit.sv
// Instruction decoder and branch resolution
`timescale 1ns/1ps
`default_nettype none

module decode_unit import arm_pkg::*; (
  input  word_t       instr,
  input  word_t       next_pc,
  input  flags_t      cond_flags,
  output reg_addr_t   rn,
  output reg_addr_t   rm,
  output reg_addr_t   rd,
  output alu_op_t     alu_op,
  output shift_am_t   shift_am,
  output logic [11:0] shift_field,
  output logic        set_flags,
  output logic        rf_write,
  output logic        uses_rm,
  output logic        branch_taken,
  output word_t       branch_target
);

  logic  is_nop;
  logic  is_dp_imm;
  logic  is_dp_reg;
  logic  is_dp;
  logic  is_branch;
  logic  cond_pass;
  logic  n, z, c, v;
  word_t offset;

  assign is_nop    = (instr == '0);
  assign is_dp_imm = !is_nop && instr[27:25] == 3'b001;
  assign is_dp_reg = !is_nop && instr[27:25] == 3'b000 && !instr[4];  // Shift by immediate
  assign is_dp     = is_dp_imm || is_dp_reg;
  assign is_branch = !is_nop && instr[27:25] == 3'b101;

  assign rn          = instr[19:16];
  assign rm          = instr[3:0];
  assign rd          = instr[15:12];
  assign shift_field = instr[11:0];
  assign shift_am    = is_dp_reg ? AM_SHIFT_REG : AM_ROT_IMM;
  assign set_flags   = is_dp && instr[20];
  assign rf_write    = is_dp && instr[24:23] != 2'b10;  // TST TEQ CMP CMN
  assign uses_rm     = is_dp_reg;

  always_comb begin
    alu_op = ALU_ADD;
    if (is_dp) begin
      case (instr[24:21])
        4'b0000, 4'b1000: alu_op = ALU_AND;  // AND, TST
        4'b0001, 4'b1001: alu_op = ALU_EOR;  // EOR, TEQ
        4'b0010, 4'b1010: alu_op = ALU_SUB;  // SUB, CMP
        4'b0011:          alu_op = ALU_RSB;
        4'b0100, 4'b1011: alu_op = ALU_ADD;  // ADD, CMN
        4'b0101:          alu_op = ALU_ADC;
        4'b0110:          alu_op = ALU_SBC;
        4'b0111:          alu_op = ALU_RSC;
        4'b1100:          alu_op = ALU_ORR;
        4'b1101:          alu_op = ALU_MOVB;
        4'b1110:          alu_op = ALU_BIC;
        default:          alu_op = ALU_MVN;
      endcase
    end
  end

  assign {n, z, c, v} = cond_flags;

  always_comb begin
    case (cond_t'(instr[31:28]))
      COND_EQ: cond_pass = z;
      COND_NE: cond_pass = !z;
      COND_CS: cond_pass = c;
      COND_CC: cond_pass = !c;
      COND_MI: cond_pass = n;
      COND_PL: cond_pass = !n;
      COND_VS: cond_pass = v;
      COND_VC: cond_pass = !v;
      COND_HI: cond_pass = c && !z;
      COND_LS: cond_pass = !c || z;
      COND_GE: cond_pass = (n == v);
      COND_LT: cond_pass = (n != v);
      COND_GT: cond_pass = !z && (n == v);
      COND_LE: cond_pass = z || (n != v);
      COND_AL: cond_pass = 1'b1;
      default: cond_pass = 1'b0;
    endcase
  end

  assign offset        = {{6{instr[23]}}, instr[23:0], 2'b00};  // Word offset in bytes
  assign branch_target = next_pc + offset;
  assign branch_taken  = is_branch && cond_pass;

  // Fetch redirect must only come from a branch word
  always_comb begin
    assert final (!branch_taken || instr[27:25] == 3'b101)
      else $error("branch taken for non-branch word %h", instr);
  end

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
// Instruction fetch stage
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import arm_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  branch_taken,
  input  word_t branch_target,
  output word_t id_instr,
  output word_t id_next_pc
);

  logic [7:0] rom [ROM_BYTES];             // Byte-wide program store
  word_t      rom_words [ROM_BYTES / 4];   // Load image, one word per line
  logic [$clog2(ROM_BYTES)-3:0] word_idx;
  word_t pc;
  word_t seq_pc;
  word_t fetch_word;

  initial begin
    for (int i = 0; i < ROM_BYTES / 4; i++) begin
      rom_words[i] = '0;                   // Unused space reads as NOP
    end
    $readmemh(ROM_FILE, rom_words);
    for (int i = 0; i < ROM_BYTES / 4; i++) begin
      rom[4 * i]     = rom_words[i][31:24];
      rom[4 * i + 1] = rom_words[i][23:16];
      rom[4 * i + 2] = rom_words[i][15:8];
      rom[4 * i + 3] = rom_words[i][7:0];
    end
  end

  assign word_idx   = pc[$clog2(ROM_BYTES)-1:2];
  assign fetch_word = {rom[{word_idx, 2'd0}], rom[{word_idx, 2'd1}],
                       rom[{word_idx, 2'd2}], rom[{word_idx, 2'd3}]};  // Big endian
  assign seq_pc     = pc + PC_STEP;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc         <= '0;
      id_instr   <= '0;                    // NOP into decode
      id_next_pc <= '0;
    end else begin
      pc         <= branch_taken ? branch_target : seq_pc;
      id_instr   <= fetch_word;
      id_next_pc <= seq_pc;
    end
  end

endmodule

`default_nettype wire

// File: rtl/forwarding_unit.sv
// Operand forwarding selects
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit import arm_pkg::*; (
  input  reg_addr_t id_rn,
  input  reg_addr_t id_rm,
  input  logic      uses_rm,
  input  reg_addr_t ex_rd,
  input  reg_addr_t mem_rd,
  input  reg_addr_t wb_rd,
  input  logic      ex_we,
  input  logic      mem_we,
  input  logic      wb_we,
  output fwd_sel_t  fwd_a,
  output fwd_sel_t  fwd_b
);

  // Nearest producing stage wins
  function automatic fwd_sel_t pick_source(reg_addr_t src);
    if (ex_we && src == ex_rd) return FWD_EX;
    if (mem_we && src == mem_rd) return FWD_MEM;
    if (wb_we && src == wb_rd) return FWD_WB;
    return FWD_NONE;
  endfunction

  always_comb begin
    fwd_a = pick_source(id_rn);
    fwd_b = uses_rm ? pick_source(id_rm) : FWD_NONE;
  end

  always_comb begin
    assert final (uses_rm || fwd_b == FWD_NONE)
      else $error("Rm forwarded for single-source instruction");
  end

endmodule

`default_nettype wire

// File: rtl/register_file.sv
// General register file
`timescale 1ns/1ps
`default_nettype none

module register_file import arm_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t ra,
  input  reg_addr_t rb,
  output word_t     pa,
  output word_t     pb,
  input  logic      we,
  input  reg_addr_t wa,
  input  word_t     wd
);

  word_t       regs [16];
  logic [15:0] write_sel;   // One-hot write decode

  assign write_sel = we ? (16'b1 << wa) : 16'b0;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 16; i++) begin
        if (write_sel[i]) regs[i] <= wd;
      end
    end
  end

  assign pa = regs[ra];
  assign pb = regs[rb];

endmodule

`default_nettype wire

// File: rtl/shifter.sv
// Operand-2 shifter
`timescale 1ns/1ps
`default_nettype none

module shifter import arm_pkg::*; (
  input  word_t       rm_val,
  input  logic [11:0] shift_field,
  input  shift_am_t   shift_am,
  output word_t       operand2
);

  logic [4:0] amount;

  function automatic word_t ror_word(word_t val, logic [4:0] amt);
    logic [63:0] pair;
    pair = {val, val} >> amt;
    return pair[31:0];
  endfunction

  assign amount = shift_field[11:7];

  always_comb begin
    case (shift_am)
      AM_ROT_IMM: operand2 = ror_word({24'b0, shift_field[7:0]}, {shift_field[11:8], 1'b0});
      AM_SHIFT_REG: begin
        case (shift_field[6:5])
          2'b00:   operand2 = rm_val << amount;               // LSL
          2'b01:   operand2 = rm_val >> amount;               // LSR
          2'b10:   operand2 = $signed(rm_val) >>> amount;     // ASR
          default: operand2 = ror_word(rm_val, amount);       // ROR
        endcase
      end
      default: operand2 = rm_val;
    endcase
  end

endmodule

`default_nettype wire

// File: testbench/arm_core_tb.sv
// ARM pipeline core testbench
`timescale 1ns/1ps
`default_nettype none

module arm_core_tb import arm_pkg::*; ;

  localparam int     RESET_CYCLES  = 16;
  localparam int     PROGRAM_WORDS = 24;
  localparam int     MAX_CYCLES    = 10 * (RESET_CYCLES + PROGRAM_WORDS);
  localparam int     NUM_RECORDS   = 16;
  localparam flags_t FINAL_FLAGS   = 4'hA;  // After the closing SUBS

  logic      clk;
  logic      reset;
  logic      wb_en;
  reg_addr_t wb_rd;
  word_t     wb_data;
  flags_t    psr_flags;

  int rec_idx;       // Next expected record
  int after_reset;   // Edges seen since reset release
  int cycle_count;

  // Expected retirements in program order
  reg_addr_t exp_rd [NUM_RECORDS] = '{
    4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8,
    4'd9, 4'd10, 4'd11, 4'd12, 4'd13, 4'd14, 4'd13, 4'd0
  };
  word_t exp_data [NUM_RECORDS] = '{
    32'hFF000000, 32'hFF0003F0, 32'hFF0003A5, 32'h3F0003A5,
    32'h2F003DF5, 32'h2E013DF2, 32'hD1F13DF2, 32'hFF2D3FF7,
    32'hFFFFFFFF, 32'h00000001, 32'h00000012, 32'h0000000F,
    32'h00000021, 32'h00000042, 32'h00000022, 32'hFFFFFFFE
  };
  // Status register seen at each retirement, one instruction later
  flags_t exp_flags [NUM_RECORDS] = '{
    4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'hA,
    4'h2, 4'h2, 4'hA, 4'h6, 4'h6, 4'h6, 4'hA, 4'hA
  };

  arm_core dut_i (
    .clk, .reset, .wb_en, .wb_rd, .wb_data, .psr_flags
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  always #10 clk = ~clk;

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;                         // Released on a falling edge
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (!reset) after_reset <= after_reset + 1;
    if (wb_en) rec_idx <= rec_idx + 1;
  end

  initial begin
    rec_idx     = 0;
    after_reset = 0;
    cycle_count = 0;
  end

  always @(posedge clk) begin
    if (cycle_count >= MAX_CYCLES) begin
      report_failure("Timeout: program did not retire all expected results");
    end
  end

  // Pipeline is empty until the fifth edge after release
  assert property (@(posedge clk) after_reset < 4 |-> !wb_en)
    else report_failure($sformatf("FAIL wb_en expected 0 got %h", $sampled(wb_en)));

  assert property (@(posedge clk) after_reset < 4 |-> psr_flags == '0)
    else report_failure($sformatf("FAIL psr_flags expected 0 got %h", $sampled(psr_flags)));

  assert property (@(posedge clk) after_reset == 4 |-> wb_en)
    else report_failure("First write-back did not arrive on the fifth edge after reset");

  assert property (@(posedge clk) wb_en |-> rec_idx < NUM_RECORDS)
    else report_failure("Write-back seen after the last expected record");

  assert property (@(posedge clk) (wb_en && rec_idx < NUM_RECORDS) |->
                   wb_rd == exp_rd[rec_idx])
    else report_failure($sformatf("FAIL wb_rd record %0d expected %h got %h",
                                  $sampled(rec_idx), exp_rd[$sampled(rec_idx)],
                                  $sampled(wb_rd)));

  assert property (@(posedge clk) (wb_en && rec_idx < NUM_RECORDS) |->
                   wb_data == exp_data[rec_idx])
    else report_failure($sformatf("FAIL wb_data record %0d expected %h got %h",
                                  $sampled(rec_idx), exp_data[$sampled(rec_idx)],
                                  $sampled(wb_data)));

  assert property (@(posedge clk) (wb_en && rec_idx < NUM_RECORDS) |->
                   psr_flags == exp_flags[rec_idx])
    else report_failure($sformatf("FAIL psr_flags record %0d expected %h got %h",
                                  $sampled(rec_idx), exp_flags[$sampled(rec_idx)],
                                  $sampled(psr_flags)));

  initial begin
    @(negedge reset);
    while (rec_idx < NUM_RECORDS) @(posedge clk);
    repeat (8) @(posedge clk);            // Closing loop must stay silent
    @(negedge clk);
    if (psr_flags == FINAL_FLAGS) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      report_failure($sformatf("FAIL psr_flags expected %h got %h", FINAL_FLAGS, psr_flags));
    end
  end

endmodule

`default_nettype wire

// File: testbench/program.hex
// One 32-bit instruction per line, address 4 * line number
// Each value is followed by its assembly form
E3A014FF  // 00 MOV  r1, #0xFF000000
E2812E3F  // 04 ADD  r2, r1, #0x3F0
E2223055  // 08 EOR  r3, r2, #0x55
E3C34103  // 0C BIC  r4, r3, #0xC0000000
E0845203  // 10 ADD  r5, r4, r3, LSL #4
E0456423  // 14 SUB  r6, r5, r3, LSR #8
E0267241  // 18 EOR  r7, r6, r1, ASR #4
E1858667  // 1C ORR  r8, r5, r7, ROR #12
E2509001  // 20 SUBS r9, r0, #1
E299A002  // 24 ADDS r10, r9, #2
E2AAB010  // 28 ADC  r11, r10, #0x10
E35A0002  // 2C CMP  r10, #2
E2CBC002  // 30 SBC  r12, r11, #2
E31C0010  // 34 TST  r12, #0x10
1A000002  // 38 BNE  0x44
E3A0D021  // 3C MOV  r13, #0x21
E3A0E042  // 40 MOV  r14, #0x42
0A000003  // 44 BEQ  0x54
E28DD001  // 48 ADD  r13, r13, #1
E3A0E0EE  // 4C MOV  r14, #0xEE
E3A0D099  // 50 MOV  r13, #0x99
E05E008D  // 54 SUBS r0, r14, r13, LSL #1
EAFFFFFF  // 58 B    0x58
00000000  // 5C NOP
